// ==== Makefile ====
TOP = pixel_stream_tb
SIM = obj_dir/V$(TOP)

all: run

# Rebuild only when a source or the file list changes
$(SIM): pixel_stream_top.f $(wildcard verilog/*.sv) $(wildcard bench/*.sv)
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f pixel_stream_top.f

run: $(SIM)
	$(SIM) | tee sim.log
	@if grep -q "Test failed" sim.log; then echo "Simulation reported failure"; exit 1; fi
	@grep -q "Test passed" sim.log || { echo "Simulation did not complete"; exit 1; }

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

// ==== bench/pixel_stream_tb.sv ====
module pixel_stream_tb;

  localparam int n_frames = 8;

  logic                                                  aclk;
  logic                                                  aresetn;
  logic                                                  s_valid;
  logic                                                  s_ready;
  logic                                                  s_last;
  logic [pixel_pkg::s_words-1:0][pixel_pkg::word_width-1:0] s_data;
  logic [pixel_pkg::s_words-1:0]                         s_keep;
  logic                                                  m_valid;
  logic                                                  m_ready;
  logic                                                  m_last;
  pixel_pkg::window_t                                    m_data;

  int frame_blk [n_frames];
  int frame_w   [n_frames];
  int frame_ci  [n_frames];
  int frame_kh2 [n_frames];
  pixel_pkg::elem_t   frame_elems [$];
  pixel_pkg::window_t exp_win [$];
  logic               exp_last [$];
  int win_errors;
  int last_errors;
  int other_errors;
  int windows_seen;
  int watchdog_cycles;
  int stall_left;
  logic stall_en;

  pixel_stream_top DUT (
    .aclk    (aclk),
    .aresetn (aresetn),
    .s_valid (s_valid),
    .s_ready (s_ready),
    .s_last  (s_last),
    .s_data  (s_data),
    .s_keep  (s_keep),
    .m_valid (m_valid),
    .m_ready (m_ready),
    .m_last  (m_last),
    .m_data  (m_data)
  );

  initial begin
    aclk = 1'b0;
    forever #4 aclk = ~aclk;
  end

  // Expected windows of one frame in output order
  function automatic void build_expected(input int n_blk, input int n_w, input int n_ci,
                                         input int kh2);
    logic [pixel_pkg::edge_words+pixel_pkg::elem_words-1:0][pixel_pkg::word_width-1:0] ext;
    pixel_pkg::window_t win;
    int idx;
    int n_elem;
    n_elem = n_blk * n_w * n_ci;
    for (int b = 0; b < n_blk; b++) begin
      for (int x = 0; x < n_w; x++) begin
        for (int c = 0; c < n_ci; c++) begin
          idx = (b * n_w + x) * n_ci + c;
          // Top halo is the bottom of the same column one block up
          for (int j = 0; j < pixel_pkg::edge_words; j++) begin
            if (b == 0) begin
              ext[j] = '0;
            end else begin
              ext[j] = frame_elems[idx - n_w * n_ci][pixel_pkg::rows - pixel_pkg::edge_words + j];
            end
          end
          for (int j = 0; j < pixel_pkg::elem_words; j++) begin
            ext[pixel_pkg::edge_words + j] = frame_elems[idx][j];
          end
          for (int k = 0; k <= 2 * kh2; k++) begin
            for (int r = 0; r < pixel_pkg::rows; r++) begin
              win[r] = ext[r + pixel_pkg::edge_words - kh2 + k];
            end
            exp_win.push_back(win);
            exp_last.push_back((idx == n_elem - 1) && (k == 2 * kh2));
          end
        end
      end
    end
  endfunction

  task automatic check_window(input pixel_pkg::window_t got, input pixel_pkg::window_t exp,
                              input int n);
    if (got !== exp) begin
      win_errors++;
      $display("Fail %0t: window %0d data %h, expected %h", $time, n, got, exp);
    end
  endtask

  task automatic check_last(input logic got, input logic exp, input int n);
    if (got !== exp) begin
      last_errors++;
      $display("Fail %0t: window %0d last %b, expected %b", $time, n, got, exp);
    end
  endtask

  task automatic send_beat(input logic [pixel_pkg::s_words-1:0][pixel_pkg::word_width-1:0] data,
                           input logic [pixel_pkg::s_words-1:0] keep, input logic last);
    logic accepted;
    s_valid  = 1'b1;
    s_data   = data;
    s_keep   = keep;
    s_last   = last;
    accepted = 1'b0;
    while (!accepted) begin
      // s_ready only depends on DUT registers, settled between edges
      accepted = s_ready;
      @(negedge aclk);
    end
    s_valid = 1'b0;
    s_last  = 1'b0;
  endtask

  task automatic send_frame(input int f);
    pixel_pkg::pixel_cfg_t hdr;
    pixel_pkg::elem_t e;
    logic [pixel_pkg::s_words-1:0][pixel_pkg::word_width-1:0] beat;
    logic [pixel_pkg::s_words-1:0] keep;
    int n_elem;
    int n_words;
    int pos;
    n_elem = frame_blk[f] * frame_w[f] * frame_ci[f];
    frame_elems.delete();
    for (int i = 0; i < n_elem; i++) begin
      for (int j = 0; j < pixel_pkg::elem_words; j++) begin
        e[j] = pixel_pkg::word_width'($urandom);
      end
      frame_elems.push_back(e);
    end
    build_expected(frame_blk[f], frame_w[f], frame_ci[f], frame_kh2[f]);
    hdr        = '0;
    hdr.blk_m1 = pixel_pkg::bits_blk'(frame_blk[f] - 1);
    hdr.w_m1   = pixel_pkg::bits_xw'(frame_w[f] - 1);
    hdr.ci_m1  = pixel_pkg::bits_ci'(frame_ci[f] - 1);
    hdr.kh2    = pixel_pkg::bits_kh2'(frame_kh2[f]);
    beat       = hdr;
    send_beat(beat, '1, 1'b0);
    n_words = n_elem * pixel_pkg::elem_words;
    pos     = 0;
    while (pos < n_words) begin
      beat = '0;
      keep = '0;
      for (int w = 0; w < pixel_pkg::s_words; w++) begin
        if (pos + w < n_words) begin
          beat[w] = frame_elems[(pos + w) / pixel_pkg::elem_words][(pos + w) % pixel_pkg::elem_words];
          keep[w] = 1'b1;
        end
      end
      pos += pixel_pkg::s_words;
      send_beat(beat, keep, pos >= n_words);
    end
  endtask

  // Sink back-pressure, random low stretches once enabled
  initial begin
    m_ready    = 1'b1;
    stall_left = 0;
    forever begin
      @(negedge aclk);
      if (stall_left > 0) begin
        m_ready = 1'b0;
        stall_left--;
      end else if (stall_en && ($urandom_range(9, 0) == 0)) begin
        m_ready    = 1'b0;
        stall_left = $urandom_range(5, 1);
      end else begin
        m_ready = 1'b1;
      end
    end
  end

  always @(posedge aclk) begin
    if (aresetn && m_valid && m_ready) begin
      if (exp_win.size() == 0) begin
        other_errors++;
        $display("Output beat at time %0t while no window was expected", $time);
      end else begin
        check_window(m_data, exp_win.pop_front(), windows_seen);
        check_last(m_last, exp_last.pop_front(), windows_seen);
      end
      windows_seen++;
    end
  end

  initial begin
    @(posedge aclk);
    repeat (watchdog_cycles) @(posedge aclk);
    $display("Timeout after %0d cycles, %0d windows never arrived",
             watchdog_cycles, exp_win.size());
    $display("Errors: window %0d, last %0d, other %0d", win_errors, last_errors, other_errors);
    $display("Test failed");
    $finish;
  end

  initial begin
    int total;
    void'($urandom(23));
    win_errors   = 0;
    last_errors  = 0;
    other_errors = 0;
    windows_seen = 0;
    stall_en     = 1'b0;
    aresetn      = 1'b0;
    s_valid      = 1'b0;
    s_last       = 1'b0;
    s_data       = '0;
    s_keep       = '0;
    // Frame 0 without halo, frame 1 with halo over four blocks
    frame_blk[0] = 2;
    frame_w[0]   = 3;
    frame_ci[0]  = 2;
    frame_kh2[0] = 0;
    frame_blk[1] = 4;
    frame_w[1]   = 5;
    frame_ci[1]  = 3;
    frame_kh2[1] = 1;
    for (int f = 2; f < n_frames; f++) begin
      frame_blk[f] = $urandom_range(pixel_pkg::blocks_max, 1);
      frame_w[f]   = $urandom_range(pixel_pkg::xw_max, 1);
      frame_ci[f]  = $urandom_range(pixel_pkg::ci_max, 1);
      frame_kh2[f] = $urandom_range(1, 0);
    end
    total = 0;
    for (int f = 0; f < n_frames; f++) begin
      total += frame_blk[f] * frame_w[f] * frame_ci[f] * (2 * frame_kh2[f] + 1);
    end
    watchdog_cycles = 40 * total + 200;

    repeat (2) @(posedge aclk);
    @(negedge aclk);
    aresetn = 1'b1;
    @(negedge aclk);
    if (s_ready !== 1'b1 || m_valid !== 1'b0) begin
      other_errors++;
      $display("After reset s_ready is %b and m_valid is %b instead of 1 and 0",
               s_ready, m_valid);
    end

    for (int f = 0; f < n_frames; f++) begin
      stall_en = (f >= 2);
      send_frame(f);
    end
    while (exp_win.size() != 0) begin
      @(posedge aclk);
    end
    // Catch stray beats after the final window
    repeat (20) @(posedge aclk);

    $display("Errors: window %0d, last %0d, other %0d", win_errors, last_errors, other_errors);
    if (win_errors + last_errors + other_errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== pixel_stream_top.f ====
verilog/pixel_pkg.sv
verilog/pixel_stream_if.sv
verilog/loop_counter.sv
verilog/word_packer.sv
verilog/edge_ram.sv
verilog/halo_row_shifter.sv
verilog/pixel_stream_top.sv
bench/pixel_stream_tb.sv

// ==== verilog/edge_ram.sv ====
module edge_ram (
  input  logic                                                   aclk,
  input  logic                                                   en,
  input  logic                                                   we,
  input  logic [pixel_pkg::bits_addr-1:0]                        addr,
  input  logic [pixel_pkg::edge_words-1:0][pixel_pkg::word_width-1:0] din,
  output logic [pixel_pkg::edge_words-1:0][pixel_pkg::word_width-1:0] dout
);

  logic [pixel_pkg::edge_words-1:0][pixel_pkg::word_width-1:0] mem [pixel_pkg::edge_depth];

  // Read data keeps its value across a write
  always_ff @(posedge aclk) begin
    if (en) begin
      if (we) begin
        mem[addr] <= din;
      end else begin
        dout <= mem[addr];
      end
    end
  end

endmodule

// ==== verilog/halo_row_shifter.sv ====
module halo_row_shifter (
  input  logic                   aclk,
  input  logic                   aresetn,
  input  logic                   s_valid,
  input  logic                   s_last,
  input  pixel_pkg::pixel_beat_u s_data,
  output logic                   s_ready,
  pixel_stream_if.src            in_m,
  pixel_stream_if.dst            elem_s,
  input  logic                   m_ready,
  output logic                   m_valid,
  output logic                   m_last,
  output pixel_pkg::window_t     m_data
);

  enum logic [1:0] {st_idle, st_pass, st_drain} state;

  logic cfg_load;
  logic s_last_beat;
  logic m_beat;
  logic m_last_beat;
  logic active;
  logic take;
  logic load;
  logic took_q;
  logic kh_last;
  logic ci_last;
  logic xw_last;
  logic blk_first;
  logic blk_last;
  logic [pixel_pkg::bits_kh2-1:0]  kh2_q;
  logic [pixel_pkg::bits_addr-1:0] ram_addr;
  logic [pixel_pkg::bits_addr-1:0] ram_addr_in;
  logic p_valid;
  logic p_last;
  logic p_first_blk;
  logic p_last_blk;
  logic [pixel_pkg::bits_addr-1:0] p_addr;
  pixel_pkg::elem_t p_data;
  logic ram_ren;
  logic ram_wen;
  logic [pixel_pkg::edge_words-1:0][pixel_pkg::word_width-1:0] ram_dout;
  logic [pixel_pkg::edge_words-1:0][pixel_pkg::word_width-1:0] edge_top;
  logic [pixel_pkg::edge_words+pixel_pkg::elem_words-1:0][pixel_pkg::word_width-1:0] shift_reg;
  logic sr_last;

  assign cfg_load    = (state == st_idle) && s_valid;
  assign s_last_beat = (state == st_pass) && s_valid && s_ready && s_last;
  assign m_beat      = m_valid && m_ready;
  assign m_last_beat = m_beat && m_last;
  assign active      = (state != st_idle);

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state <= st_idle;
    end else begin
      case (state)
        st_idle:  if (cfg_load) state <= st_pass;
        st_pass:  if (s_last_beat) state <= st_drain;
        st_drain: if (m_last_beat) state <= st_idle;
        default:  state <= st_idle;
      endcase
    end
  end

  // Input gating towards the packer
  always_comb begin
    s_ready    = 1'b0;
    in_m.valid = 1'b0;
    case (state)
      st_idle: s_ready = 1'b1;
      st_pass: begin
        s_ready    = in_m.ready;
        in_m.valid = s_valid;
      end
      default: ;
    endcase
  end

  assign in_m.last = s_last;
  assign in_m.data = s_data.words;

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      kh2_q <= '0;
    end else if (cfg_load) begin
      kh2_q <= s_data.cfg.kh2;
    end
  end

  // Kernel row counts output beats, the others count taken elements
  loop_counter #(.W(pixel_pkg::bits_kh)) u_cnt_kh (
    .aclk    (aclk),
    .aresetn (aresetn),
    .load    (cfg_load),
    .en      (m_beat),
    .limit   (pixel_pkg::bits_kh'(2 * s_data.cfg.kh2)),
    .last    (kh_last),
    .first   ()
  );

  loop_counter #(.W(pixel_pkg::bits_ci)) u_cnt_ci (
    .aclk    (aclk),
    .aresetn (aresetn),
    .load    (cfg_load),
    .en      (take),
    .limit   (s_data.cfg.ci_m1),
    .last    (ci_last),
    .first   ()
  );

  loop_counter #(.W(pixel_pkg::bits_xw)) u_cnt_xw (
    .aclk    (aclk),
    .aresetn (aresetn),
    .load    (cfg_load),
    .en      (take && ci_last),
    .limit   (s_data.cfg.w_m1),
    .last    (xw_last),
    .first   ()
  );

  loop_counter #(.W(pixel_pkg::bits_blk)) u_cnt_blk (
    .aclk    (aclk),
    .aresetn (aresetn),
    .load    (cfg_load),
    .en      (take && ci_last && xw_last),
    .limit   (s_data.cfg.blk_m1),
    .last    (blk_last),
    .first   (blk_first)
  );

  // Shift register free next cycle, element moves in
  assign load = m_ready && p_valid && (!m_valid || kh_last);

  // No take right after one while halos matter, so the edge write lands first
  assign elem_s.ready = active && m_ready && (!p_valid || load)
                        && !(took_q && (kh2_q != '0));
  assign take         = elem_s.valid && elem_s.ready;

  always_ff @(posedge aclk) begin
    if (cfg_load || (take && ci_last && xw_last)) begin
      ram_addr <= '0;
    end else if (take) begin
      ram_addr <= ram_addr + 1'b1;
    end
  end

  assign ram_ren     = take && !blk_first;
  assign ram_wen     = took_q && !p_last_blk;
  assign ram_addr_in = ram_wen ? p_addr : ram_addr;

  edge_ram u_edge_ram (
    .aclk (aclk),
    .en   (ram_ren || ram_wen),
    .we   (ram_wen),
    .addr (ram_addr_in),
    .din  (p_data[pixel_pkg::rows-1:pixel_pkg::rows-pixel_pkg::edge_words]),
    .dout (ram_dout)
  );

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      p_valid <= 1'b0;
      took_q  <= 1'b0;
      m_valid <= 1'b0;
    end else begin
      took_q <= take;
      if (take) begin
        p_valid <= 1'b1;
      end else if (load) begin
        p_valid <= 1'b0;
      end
      if (load) begin
        m_valid <= 1'b1;
      end else if (m_beat && kh_last) begin
        m_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (take) begin
      p_data      <= elem_s.data;
      p_last      <= elem_s.last;
      p_first_blk <= blk_first;
      p_last_blk  <= blk_last;
      p_addr      <= ram_addr;
    end
  end

  // Block 0 has no block above it
  assign edge_top = p_first_blk ? '0 : ram_dout;

  always_ff @(posedge aclk) begin
    if (load) begin
      shift_reg <= {p_data, edge_top};
      sr_last   <= p_last;
    end else if (m_beat) begin
      shift_reg <= shift_reg >> pixel_pkg::word_width;
    end
  end

  // Window starts kh2 words above the block
  always_comb begin
    for (int r = 0; r < pixel_pkg::rows; r++) begin
      m_data[r] = shift_reg[r + pixel_pkg::edge_words - int'(kh2_q)];
    end
  end

  assign m_last = m_valid && sr_last && kh_last;

endmodule

// ==== verilog/loop_counter.sv ====
module loop_counter #(
  parameter int W = 2
) (
  input  logic         aclk,
  input  logic         aresetn,
  input  logic         load,
  input  logic         en,
  input  logic [W-1:0] limit,
  output logic         last,
  output logic         first
);

  logic [W-1:0] count;
  logic [W-1:0] limit_q;

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      count   <= '0;
      limit_q <= '0;
    end else if (load) begin
      count   <= '0;
      limit_q <= limit;
    end else if (en) begin
      // Wrap back to zero after the limit
      if (last) begin
        count <= '0;
      end else begin
        count <= count + 1'b1;
      end
    end
  end

  assign last  = (count == limit_q);
  assign first = (count == '0);

endmodule

// ==== verilog/pixel_pkg.sv ====
package pixel_pkg;

  // Pixel and block geometry
  localparam int word_width = 8;
  localparam int rows       = 4;
  localparam int kh_max     = 3;
  localparam int edge_words = kh_max / 2;
  localparam int elem_words = rows + edge_words;
  localparam int s_words    = 4;
  localparam int beat_width = s_words * word_width;

  // Largest frame the counters and the edge RAM cover
  localparam int ci_max     = 4;
  localparam int xw_max     = 8;
  localparam int blocks_max = 4;
  localparam int edge_depth = ci_max * xw_max;

  // Packer staging buffer holds two beats
  localparam int stage_words = elem_words + s_words - 1;
  localparam int bits_stage  = $clog2(stage_words + 1);

  localparam int bits_kh   = $clog2(kh_max);
  localparam int bits_kh2  = $clog2((kh_max + 1) / 2);
  localparam int bits_ci   = $clog2(ci_max);
  localparam int bits_xw   = $clog2(xw_max);
  localparam int bits_blk  = $clog2(blocks_max);
  localparam int bits_addr = bits_ci + bits_xw;

  localparam int cfg_pad = beat_width - bits_blk - bits_xw - bits_ci - bits_kh2;

  // Header beat, kernel half-height in the low bits
  typedef struct packed {
    logic [cfg_pad-1:0]  pad;
    logic [bits_blk-1:0] blk_m1;
    logic [bits_xw-1:0]  w_m1;
    logic [bits_ci-1:0]  ci_m1;
    logic [bits_kh2-1:0] kh2;
  } pixel_cfg_t;

  // First beat of a frame is a header, every later one carries pixels
  typedef union packed {
    pixel_cfg_t                            cfg;
    logic [s_words-1:0][word_width-1:0]    words;
  } pixel_beat_u;

  // One column of one channel, rows plus look-ahead
  typedef logic [elem_words-1:0][word_width-1:0] elem_t;

  typedef logic [rows-1:0][word_width-1:0] window_t;

endpackage

// ==== verilog/pixel_stream_if.sv ====
interface pixel_stream_if #(
  parameter int n_words = 1
);

  logic                                       valid;
  logic                                       ready;
  logic                                       last;
  logic [n_words-1:0][pixel_pkg::word_width-1:0] data;
  logic [n_words-1:0]                         keep;

  modport src (
    output valid,
    output last,
    output data,
    output keep,
    input  ready
  );

  modport dst (
    input  valid,
    input  last,
    input  data,
    input  keep,
    output ready
  );

endinterface

// ==== verilog/pixel_stream_top.sv ====
module pixel_stream_top (
  input  logic                                                  aclk,
  input  logic                                                  aresetn,
  input  logic                                                  s_valid,
  output logic                                                  s_ready,
  input  logic                                                  s_last,
  input  logic [pixel_pkg::s_words-1:0][pixel_pkg::word_width-1:0] s_data,
  input  logic [pixel_pkg::s_words-1:0]                         s_keep,
  output logic                                                  m_valid,
  input  logic                                                  m_ready,
  output logic                                                  m_last,
  output logic [pixel_pkg::rows-1:0][pixel_pkg::word_width-1:0]    m_data
);

  pixel_stream_if #(.n_words(pixel_pkg::s_words))    in_if ();
  pixel_stream_if #(.n_words(pixel_pkg::elem_words)) elem_if ();

  // Keep bypasses the shifter, it only gates valid and ready
  assign in_if.keep = s_keep;

  halo_row_shifter u_shifter (
    .aclk    (aclk),
    .aresetn (aresetn),
    .s_valid (s_valid),
    .s_last  (s_last),
    .s_data  (pixel_pkg::pixel_beat_u'(s_data)),
    .s_ready (s_ready),
    .in_m    (in_if.src),
    .elem_s  (elem_if.dst),
    .m_ready (m_ready),
    .m_valid (m_valid),
    .m_last  (m_last),
    .m_data  (m_data)
  );

  word_packer u_packer (
    .aclk    (aclk),
    .aresetn (aresetn),
    .in_s    (in_if.dst),
    .out_m   (elem_if.src)
  );

endmodule

// ==== verilog/word_packer.sv ====
module word_packer (
  input  logic        aclk,
  input  logic        aresetn,
  pixel_stream_if.dst in_s,
  pixel_stream_if.src out_m
);

  logic [pixel_pkg::stage_words-1:0][pixel_pkg::word_width-1:0] stage_q;
  logic [pixel_pkg::stage_words-1:0][pixel_pkg::word_width-1:0] merged;
  logic [pixel_pkg::bits_stage-1:0] count_q;
  logic [pixel_pkg::bits_stage-1:0] merged_cnt;
  logic [pixel_pkg::bits_stage-1:0] rest_cnt;
  logic last_q;
  logic merged_last;
  logic take;
  logic out_free;
  logic move;

  // Room for one more full beat
  assign in_s.ready = (count_q <= pixel_pkg::bits_stage'(pixel_pkg::stage_words
                                                        - pixel_pkg::s_words));
  assign take       = in_s.valid && in_s.ready;

  // Append the kept words of the incoming beat
  always_comb begin
    merged      = stage_q;
    merged_cnt  = count_q;
    merged_last = last_q;
    if (take) begin
      for (int i = 0; i < pixel_pkg::s_words; i++) begin
        if (in_s.keep[i]) begin
          merged[int'(count_q) + i] = in_s.data[i];
        end
      end
      merged_cnt  = count_q + pixel_pkg::bits_stage'($countones(in_s.keep));
      merged_last = last_q || in_s.last;
    end
  end

  assign out_free = !out_m.valid || out_m.ready;
  assign move     = out_free
                    && (merged_cnt >= pixel_pkg::bits_stage'(pixel_pkg::elem_words));
  assign rest_cnt = merged_cnt - pixel_pkg::bits_stage'(pixel_pkg::elem_words);

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      count_q     <= '0;
      last_q      <= 1'b0;
      out_m.valid <= 1'b0;
      out_m.last  <= 1'b0;
    end else if (move) begin
      count_q     <= rest_cnt;
      // Frame end stays pending until the words behind it are out
      last_q      <= merged_last && (rest_cnt != '0);
      out_m.valid <= 1'b1;
      out_m.last  <= merged_last && (rest_cnt == '0);
    end else begin
      count_q     <= merged_cnt;
      last_q      <= merged_last;
      if (out_m.ready) begin
        out_m.valid <= 1'b0;
      end
    end
  end

  // Element out, remainder shifted down to word 0
  always_ff @(posedge aclk) begin
    if (move) begin
      stage_q    <= merged >> (pixel_pkg::elem_words * pixel_pkg::word_width);
      out_m.data <= merged[pixel_pkg::elem_words-1:0];
    end else begin
      stage_q    <= merged;
    end
  end

  assign out_m.keep = '1;

endmodule
